/* common/ee_settings.svh */
`ifndef EE_SETTINGS_SVH
`define EE_SETTINGS_SVH

`define EE_ADDR_W         11
`define EE_TAG_W          3
`define EE_FIFO_DEPTH     4
`define EE_QUARTER_CYCLES 2
`define EE_DEV_CODE       4'b1010

// op + tag + address + data
`define EE_CMD_W          (1 + `EE_TAG_W + `EE_ADDR_W + 8)

`endif

/* common/ee_cmd_pkg.sv */
// request-level types, shared from host capture to completion
package ee_cmd_pkg;

    // request kind, packed as the top bit of a queue word
    typedef enum logic [0:0]
    {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } cmd_op_t;

    // direction bit of the control byte follows the op encoding
    localparam logic DIR_WRITE = 1'b0;
    localparam logic DIR_READ  = 1'b1;

endpackage

/* common/ee_bus_pkg.sv */
// two-wire bus side: engine states and shifter operations
package ee_bus_pkg;

    typedef enum logic [3:0]
    {
        ST_IDLE    = 4'd0,
        ST_START   = 4'd1,
        ST_CTRL_WR = 4'd2,
        ST_ADDR_WR = 4'd3,
        ST_DATA_WR = 4'd4,
        ST_RESTART = 4'd5,
        ST_CTRL_RD = 4'd6,
        ST_DATA_RD = 4'd7,
        ST_STOP    = 4'd8,
        ST_DONE    = 4'd9
    } eng_state_t;

    typedef enum logic [1:0]
    {
        SH_START = 2'd0,
        SH_STOP  = 2'd1,
        SH_TX    = 2'd2,
        SH_RX    = 2'd3
    } sh_op_t;

endpackage

/* rtl/ee_req_capture.sv */
`timescale 1ns/1ps
`include "ee_settings.svh"

module ee_req_capture import ee_cmd_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr,
    input  logic                  rd,
    input  logic [`EE_ADDR_W-1:0] addr,
    input  logic [7:0]            wdata,
    input  logic                  fifo_full,
    output logic                  fifo_push,
    output logic [`EE_CMD_W-1:0]  fifo_wdata,
    output logic                  req_drop
);

    logic                 strobe;
    logic                 accept;
    cmd_op_t              req_op;
    logic [`EE_TAG_W-1:0] tag;

    assign strobe = wr | rd;
    assign accept = strobe & ~fifo_full;
    assign req_op = wr ? OP_WRITE : OP_READ; // wr wins, rd dropped silently

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            fifo_push <= 1'b0;
            req_drop  <= 1'b0;
            tag       <= '0;
        end
        else
        begin
            fifo_push <= accept;
            req_drop  <= strobe & fifo_full;
            if (accept)
                tag <= tag + 1'b1; // wraps mod 8
        end
    end

    always_ff @(posedge CLK)
    begin
        if (strobe)
            fifo_wdata <= {req_op, tag, addr, wdata};
    end

endmodule

/* rtl/ee_cmd_fifo.sv */
`timescale 1ns/1ps
`include "ee_settings.svh"

module ee_cmd_fifo
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 push,
    input  logic [`EE_CMD_W-1:0] wdata,
    input  logic                 pop,
    output logic [`EE_CMD_W-1:0] rdata,
    output logic                 empty,
    output logic                 full
);

    localparam int DEPTH = `EE_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [`EE_CMD_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     count;
    logic                 do_push;
    logic                 do_pop;

    assign do_pop  = pop && (count != '0);
    assign do_push = push && ((count != CNT_W'(DEPTH)) || do_pop);

    assign rdata = mem[rd_ptr]; // show-ahead head
    assign empty = (count == '0);

    // capture registers its push, so the one in flight already takes a slot
    assign full = (int'(count) + int'(push)) >= DEPTH;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (do_push)
            mem[wr_ptr] <= wdata;
    end

endmodule

/* ee_serial_engine/ee_bit_shifter.sv */
`timescale 1ns/1ps
`include "ee_settings.svh"

module ee_bit_shifter import ee_bus_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       go,
    input  sh_op_t     op,
    input  logic [7:0] txbyte,
    input  logic       rx_nack,
    input  logic       sda_in,
    output logic       done,
    output logic [7:0] rxbyte,
    output logic       ack_seen,
    output logic       SCL,
    output logic       sda_low
);

    localparam int QC    = `EE_QUARTER_CYCLES;
    localparam int DIV_W = (QC > 1) ? $clog2(QC) : 1;

    logic             busy;
    logic [DIV_W-1:0] div;
    logic             tick;
    logic [1:0]       qtr;
    logic [3:0]       bit_cnt;
    logic [3:0]       last_bit;
    logic             at_end;
    sh_op_t           op_r;
    logic [7:0]       tx_r;
    logic             rx_nack_r;

    sh_op_t     cur_op;
    logic [7:0] cur_tx;
    logic       cur_nack;
    logic [1:0] nxt_qtr;
    logic [3:0] nxt_bit;
    logic [2:0] tx_idx;
    logic       scl_nx;
    logic       sdl_nx;

    assign tick     = busy && (div == DIV_W'(QC - 1));
    assign last_bit = (op_r == SH_TX || op_r == SH_RX) ? 4'd8 : 4'd0; // 8 data + ack
    assign at_end   = (qtr == 2'd3) && (bit_cnt == last_bit);

    // pin levels for the quarter being entered
    always_comb
    begin
        cur_op   = go ? op : op_r;
        cur_tx   = go ? txbyte : tx_r;
        cur_nack = go ? rx_nack : rx_nack_r;
        nxt_qtr  = go ? 2'd0 : qtr + 2'd1;
        nxt_bit  = go ? 4'd0 : ((qtr == 2'd3) ? bit_cnt + 4'd1 : bit_cnt);
        tx_idx   = 3'd7 - nxt_bit[2:0]; // msb first
        scl_nx   = SCL;
        sdl_nx   = sda_low;
        case (cur_op)
            SH_START:
                case (nxt_qtr)
                    2'd0: sdl_nx = 1'b0;
                    2'd1: scl_nx = 1'b1;
                    2'd2: sdl_nx = 1'b1; // sda falls, scl high
                    default: scl_nx = 1'b0;
                endcase
            SH_STOP:
                case (nxt_qtr)
                    2'd0:
                    begin
                        scl_nx = 1'b0;
                        sdl_nx = 1'b1;
                    end
                    2'd1: scl_nx = 1'b1;
                    2'd2: sdl_nx = 1'b0; // sda rises, scl high
                    default: ;
                endcase
            default:
                case (nxt_qtr)
                    2'd0:
                    begin
                        scl_nx = 1'b0;
                        if (nxt_bit == 4'd8)
                            sdl_nx = (cur_op == SH_RX) && !cur_nack;
                        else
                            sdl_nx = (cur_op == SH_TX) && !cur_tx[tx_idx];
                    end
                    2'd1, 2'd2: scl_nx = 1'b1;
                    default: scl_nx = 1'b0;
                endcase
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy    <= 1'b0;
            done    <= 1'b0;
            div     <= '0;
            SCL     <= 1'b1;
            sda_low <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (busy)
                div <= tick ? '0 : div + 1'b1;
            if (go)
            begin
                busy      <= 1'b1;
                div       <= '0;
                qtr       <= nxt_qtr;
                bit_cnt   <= nxt_bit;
                op_r      <= op;
                tx_r      <= txbyte;
                rx_nack_r <= rx_nack;
                SCL       <= scl_nx;
                sda_low   <= sdl_nx;
            end
            else if (tick)
            begin
                if (at_end)
                begin
                    busy <= 1'b0; // pins stay at their last quarter
                    done <= 1'b1;
                end
                else
                begin
                    qtr     <= nxt_qtr;
                    bit_cnt <= nxt_bit;
                    SCL     <= scl_nx;
                    sda_low <= sdl_nx;
                end
            end
        end
    end

    // sample at mid-high, end of quarter 1
    always_ff @(posedge CLK)
    begin
        if (tick && qtr == 2'd1)
        begin
            if (op_r == SH_TX && bit_cnt == 4'd8)
                ack_seen <= !sda_in;
            else if (op_r == SH_RX && bit_cnt < 4'd8)
                rxbyte <= {rxbyte[6:0], sda_in};
        end
    end

endmodule

/* ee_serial_engine/ee_serial_engine.sv */
`timescale 1ns/1ps
`include "ee_settings.svh"

module ee_serial_engine import ee_cmd_pkg::*, ee_bus_pkg::*;
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic [`EE_CMD_W-1:0] fifo_rdata,
    input  logic                 fifo_empty,
    output logic                 fifo_pop,
    output logic                 sh_go,
    output sh_op_t               sh_op,
    output logic [7:0]           sh_txbyte,
    output logic                 sh_rx_nack,
    input  logic                 sh_done,
    input  logic [7:0]           sh_rxbyte,
    input  logic                 sh_ack_seen,
    output logic                 done,
    output logic [`EE_TAG_W-1:0] done_tag,
    output cmd_op_t              done_op,
    output logic [7:0]           rd_data,
    output logic                 nack
);

    // queue word layout {op, tag, addr, data}
    localparam int ADDR_LSB = 8;
    localparam int TAG_LSB  = 8 + `EE_ADDR_W;
    localparam int OP_BIT   = `EE_CMD_W - 1;

    eng_state_t            state;
    cmd_op_t               op_r;
    logic [`EE_TAG_W-1:0]  tag_r;
    logic [`EE_ADDR_W-1:0] addr_r;
    logic [7:0]            data_r;
    logic [7:0]            rx_r;
    logic                  nack_r;
    logic [2:0]            blk;

    assign blk      = addr_r[`EE_ADDR_W-1 -: 3];
    assign fifo_pop = (state == ST_IDLE) && !fifo_empty;

    // one shifter command, go is cleared again by the default below
    task launch(input sh_op_t o, input logic [7:0] b);
        begin
            sh_go      <= 1'b1;
            sh_op      <= o;
            sh_txbyte  <= b;
            sh_rx_nack <= (o == SH_RX); // single-byte read always ends in nack
        end
    endtask

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= ST_IDLE;
            sh_go <= 1'b0;
            done  <= 1'b0;
        end
        else
        begin
            sh_go <= 1'b0;
            done  <= 1'b0;
            case (state)
                ST_IDLE:
                    if (!fifo_empty)
                    begin
                        op_r   <= cmd_op_t'(fifo_rdata[OP_BIT]);
                        tag_r  <= fifo_rdata[TAG_LSB +: `EE_TAG_W];
                        addr_r <= fifo_rdata[ADDR_LSB +: `EE_ADDR_W];
                        data_r <= fifo_rdata[7:0];
                        nack_r <= 1'b0;
                        launch(SH_START, 8'h00);
                        state  <= ST_START;
                    end
                ST_START:
                    if (sh_done)
                    begin
                        launch(SH_TX, {`EE_DEV_CODE, blk, DIR_WRITE});
                        state <= ST_CTRL_WR;
                    end
                ST_CTRL_WR:
                    if (sh_done)
                    begin
                        if (!sh_ack_seen)
                        begin
                            nack_r <= 1'b1;
                            launch(SH_STOP, 8'h00);
                            state  <= ST_STOP;
                        end
                        else
                        begin
                            launch(SH_TX, addr_r[7:0]);
                            state <= ST_ADDR_WR;
                        end
                    end
                ST_ADDR_WR:
                    if (sh_done)
                    begin
                        if (!sh_ack_seen)
                        begin
                            nack_r <= 1'b1;
                            launch(SH_STOP, 8'h00);
                            state  <= ST_STOP;
                        end
                        else if (op_r == OP_WRITE)
                        begin
                            launch(SH_TX, data_r);
                            state <= ST_DATA_WR;
                        end
                        else
                        begin
                            launch(SH_START, 8'h00); // repeated start
                            state <= ST_RESTART;
                        end
                    end
                ST_DATA_WR:
                    if (sh_done)
                    begin
                        nack_r <= !sh_ack_seen;
                        launch(SH_STOP, 8'h00);
                        state  <= ST_STOP;
                    end
                ST_RESTART:
                    if (sh_done)
                    begin
                        launch(SH_TX, {`EE_DEV_CODE, blk, DIR_READ});
                        state <= ST_CTRL_RD;
                    end
                ST_CTRL_RD:
                    if (sh_done)
                    begin
                        if (!sh_ack_seen)
                        begin
                            nack_r <= 1'b1;
                            launch(SH_STOP, 8'h00);
                            state  <= ST_STOP;
                        end
                        else
                        begin
                            launch(SH_RX, 8'h00);
                            state <= ST_DATA_RD;
                        end
                    end
                ST_DATA_RD:
                    if (sh_done)
                    begin
                        rx_r  <= sh_rxbyte;
                        launch(SH_STOP, 8'h00);
                        state <= ST_STOP;
                    end
                ST_STOP:
                    if (sh_done)
                    begin
                        // completion outputs change only here
                        done     <= 1'b1;
                        done_tag <= tag_r;
                        done_op  <= op_r;
                        rd_data  <= rx_r;
                        nack     <= nack_r;
                        state    <= ST_DONE;
                    end
                ST_DONE:
                    state <= ST_IDLE;
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

endmodule

/* rtl/ee_ctrl_top.sv */
`timescale 1ns/1ps
`include "ee_settings.svh"

module ee_ctrl_top import ee_cmd_pkg::*, ee_bus_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr,
    input  logic                  rd,
    input  logic [`EE_ADDR_W-1:0] addr,
    input  logic [7:0]            wdata,
    output logic                  req_drop,
    output logic                  done,
    output logic [`EE_TAG_W-1:0]  done_tag,
    output cmd_op_t               done_op,
    output logic [7:0]            rd_data,
    output logic                  nack,
    output logic                  SCL,
    inout  wire                   SDA
);

    logic                 fifo_push;
    logic [`EE_CMD_W-1:0] fifo_wdata;
    logic                 fifo_full;
    logic [`EE_CMD_W-1:0] fifo_rdata;
    logic                 fifo_empty;
    logic                 fifo_pop;
    logic                 sh_go;
    sh_op_t               sh_op;
    logic [7:0]           sh_txbyte;
    logic                 sh_rx_nack;
    logic                 sh_done;
    logic [7:0]           sh_rxbyte;
    logic                 sh_ack_seen;
    logic                 sda_low;
    logic                 sda_in;

    assign SDA    = sda_low ? 1'b0 : 1'bz; // open drain, pull-up on the board
    assign sda_in = SDA;

    ee_req_capture u_capture
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .wr         (wr),
        .rd         (rd),
        .addr       (addr),
        .wdata      (wdata),
        .fifo_full  (fifo_full),
        .fifo_push  (fifo_push),
        .fifo_wdata (fifo_wdata),
        .req_drop   (req_drop)
    );

    ee_cmd_fifo u_fifo
    (
        .CLK   (CLK),
        .RESET (RESET),
        .push  (fifo_push),
        .wdata (fifo_wdata),
        .pop   (fifo_pop),
        .rdata (fifo_rdata),
        .empty (fifo_empty),
        .full  (fifo_full)
    );

    ee_serial_engine u_engine
    (
        .CLK         (CLK),
        .RESET       (RESET),
        .fifo_rdata  (fifo_rdata),
        .fifo_empty  (fifo_empty),
        .fifo_pop    (fifo_pop),
        .sh_go       (sh_go),
        .sh_op       (sh_op),
        .sh_txbyte   (sh_txbyte),
        .sh_rx_nack  (sh_rx_nack),
        .sh_done     (sh_done),
        .sh_rxbyte   (sh_rxbyte),
        .sh_ack_seen (sh_ack_seen),
        .done        (done),
        .done_tag    (done_tag),
        .done_op     (done_op),
        .rd_data     (rd_data),
        .nack        (nack)
    );

    ee_bit_shifter u_shifter
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .go       (sh_go),
        .op       (sh_op),
        .txbyte   (sh_txbyte),
        .rx_nack  (sh_rx_nack),
        .sda_in   (sda_in),
        .done     (sh_done),
        .rxbyte   (sh_rxbyte),
        .ack_seen (sh_ack_seen),
        .SCL      (SCL),
        .sda_low  (sda_low)
    );

endmodule

/* verif/ee_eeprom_model.sv */
`timescale 1ns/1ps

module ee_eeprom_model
(
    input  wire scl,
    inout  wire sda
);

    localparam int P_CTRL   = 0;
    localparam int P_ADDR   = 1;
    localparam int P_WDATA  = 2;
    localparam int P_RDATA  = 3;
    localparam int P_IGNORE = 4;

    logic [7:0]  mem [2048];
    logic [10:0] ptr;
    logic [7:0]  shreg;
    logic [7:0]  tx_byte;
    logic        drive_low;
    logic        active;
    logic        skip_fall;
    int          bit_cnt;
    int          phase;
    int          next_phase;
    int          i;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial
    begin
        drive_low  = 1'b0;
        active     = 1'b0;
        skip_fall  = 1'b0;
        bit_cnt    = 0;
        phase      = P_IGNORE;
        next_phase = P_IGNORE;
        ptr        = '0;
        for (i = 0; i < 2048; i++)
            mem[i] = 8'h00;
    end

    // decide the ack for a byte just received
    task automatic take_byte;
        logic ack;
        begin
            ack = 1'b1;
            case (phase)
                P_CTRL:
                    if (shreg[7:4] != 4'b1010 || shreg[3:1] == 3'd7)
                    begin
                        ack        = 1'b0; // block 7 is not there
                        next_phase = P_IGNORE;
                    end
                    else
                    begin
                        ptr[10:8]  = shreg[3:1];
                        next_phase = shreg[0] ? P_RDATA : P_ADDR;
                    end
                P_ADDR:
                begin
                    ptr[7:0]   = shreg;
                    next_phase = P_WDATA;
                end
                P_WDATA:
                begin
                    mem[ptr]   = shreg;
                    next_phase = P_IGNORE; // single byte writes only
                end
                default:
                begin
                    ack        = 1'b0;
                    next_phase = P_IGNORE;
                end
            endcase
            drive_low = ack;
        end
    endtask

    // start or repeated start
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            active    = 1'b1;
            skip_fall = 1'b1; // scl falls once more before bit 0
            bit_cnt   = 0;
            phase     = P_CTRL;
            drive_low = 1'b0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            active    = 1'b0; // stop
            drive_low = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (active && bit_cnt < 8 && phase != P_RDATA)
            shreg = {shreg[6:0], sda === 1'b1};
    end

    always @(negedge scl)
    begin
        if (active)
        begin
            if (skip_fall)
                skip_fall = 1'b0;
            else if (bit_cnt < 7)
            begin
                bit_cnt = bit_cnt + 1;
                if (phase == P_RDATA)
                    drive_low = !tx_byte[7 - bit_cnt];
            end
            else if (bit_cnt == 7)
            begin
                bit_cnt = 8;
                if (phase == P_RDATA)
                    drive_low = 1'b0; // master acks here
                else
                    take_byte();
            end
            else
            begin
                bit_cnt   = 0;
                drive_low = 1'b0;
                phase     = next_phase;
                if (phase == P_RDATA)
                begin
                    tx_byte    = mem[ptr];
                    drive_low  = !tx_byte[7];
                    next_phase = P_IGNORE;
                end
            end
        end
    end

endmodule

/* verif/ee_ctrl_checker.sv */
`timescale 1ns/1ps
`include "ee_settings.svh"

module ee_ctrl_checker import ee_cmd_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr,
    input  logic                  rd,
    input  logic [`EE_ADDR_W-1:0] addr,
    input  logic [7:0]            wdata,
    input  logic                  req_drop,
    input  logic                  done,
    input  logic [`EE_TAG_W-1:0]  done_tag,
    input  cmd_op_t               done_op,
    input  logic [7:0]            rd_data,
    input  logic                  nack,
    input  logic                  scl,
    input  logic                  sda,
    output int                    error_count,
    output int                    check_count,
    output int                    done_count,
    output int                    drop_count,
    output int                    busy_count,
    output int                    idle_checks,
    output int                    idle_errors
);

    logic [7:0]            ref_mem [2048];
    cmd_op_t               q_op [$];
    logic [`EE_TAG_W-1:0]  q_tag [$];
    logic [`EE_ADDR_W-1:0] q_addr [$];
    logic [7:0]            q_data [$];
    logic                  pend;
    cmd_op_t               pend_op;
    logic [`EE_ADDR_W-1:0] pend_addr;
    logic [7:0]            pend_data;
    logic [`EE_TAG_W-1:0]  next_tag;
    logic                  idle_due;
    cmd_op_t               exp_op;
    logic [`EE_TAG_W-1:0]  exp_tag;
    logic [`EE_ADDR_W-1:0] exp_addr;
    logic [7:0]            exp_data;
    logic                  exp_nack;
    int                    i;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        begin
            check_count++;
            if (actual !== expected)
            begin
                error_count++;
                $display("ERROR %s: expected %h, got %h at %0t", name, expected, actual, $time);
            end
        end
    endtask

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            pend     = 1'b0;
            next_tag = '0;
            idle_due = 1'b1; // bus must be idle once reset is over
            q_op.delete();
            q_tag.delete();
            q_addr.delete();
            q_data.delete();
            for (i = 0; i < 2048; i++)
                ref_mem[i] = 8'h00;
        end
        else
        begin
            if (idle_due)
            begin
                idle_checks++;
                if (scl !== 1'b1 || sda !== 1'b1)
                    idle_errors++;
                check_value("SCL", 1, scl);
                check_value("SDA", 1, sda);
                idle_due = 1'b0;
            end
            if (done)
            begin
                done_count++;
                idle_due = 1'b1;
                if (q_op.size() == 0)
                begin
                    error_count++;
                    $display("done pulse at %0t with no request outstanding", $time);
                end
                else
                begin
                    exp_op   = q_op.pop_front();
                    exp_tag  = q_tag.pop_front();
                    exp_addr = q_addr.pop_front();
                    exp_data = q_data.pop_front();
                    exp_nack = (exp_addr[`EE_ADDR_W-1 -: 3] == 3'd7);
                    check_value("done_tag", exp_tag, done_tag);
                    check_value("done_op", exp_op, done_op);
                    check_value("nack", exp_nack, nack);
                    if (exp_op == OP_READ && !exp_nack)
                        check_value("rd_data", exp_data, rd_data);
                end
            end
            if (req_drop && !pend)
            begin
                error_count++;
                $display("req_drop at %0t without a request one cycle before", $time);
            end
            if (pend)
            begin
                if (req_drop)
                begin
                    drop_count++;
                    if (q_op.size() < `EE_FIFO_DEPTH)
                    begin
                        error_count++;
                        $display("request dropped at %0t with only %0d outstanding",
                                 $time, q_op.size());
                    end
                end
                else
                begin
                    q_op.push_back(pend_op);
                    q_tag.push_back(next_tag);
                    q_addr.push_back(pend_addr);
                    if (pend_op == OP_WRITE)
                    begin
                        if (pend_addr[`EE_ADDR_W-1 -: 3] != 3'd7)
                            ref_mem[pend_addr] = pend_data;
                        q_data.push_back(pend_data);
                    end
                    else
                        q_data.push_back(ref_mem[pend_addr]); // sees all earlier writes
                    next_tag = next_tag + 1'b1;
                end
            end
            pend      = wr | rd;
            pend_op   = wr ? OP_WRITE : OP_READ; // wr has priority
            pend_addr = addr;
            pend_data = wdata;
        end
        busy_count = q_op.size() + int'(pend);
    end

endmodule

/* verif/ee_ctrl_tb.sv */
`timescale 1ns/1ps
`include "ee_settings.svh"

module ee_ctrl_tb import ee_cmd_pkg::*;
();

    localparam longint N_REQ       = 86;
    localparam longint WATCHDOG_NS = N_REQ * 39 * 4 * `EE_QUARTER_CYCLES * 10 * 2
                                     + 40 * 400 * 10; // plus the gaps of test 2

    logic                  CLK;
    logic                  RESET;
    logic                  wr;
    logic                  rd;
    logic [`EE_ADDR_W-1:0] addr;
    logic [7:0]            wdata;
    logic                  req_drop;
    logic                  done;
    logic [`EE_TAG_W-1:0]  done_tag;
    cmd_op_t               done_op;
    logic [7:0]            rd_data;
    logic                  nack;
    logic                  scl;
    wire                   sda;

    int error_count;
    int check_count;
    int done_count;
    int drop_count;
    int busy_count;
    int idle_checks;
    int idle_errors;

    integer                seed;
    int                    fails;
    int                    mark;
    int                    i;
    int                    gap;
    int                    drops_before;
    logic [`EE_ADDR_W-1:0] a;
    logic [7:0]            d;
    logic [`EE_ADDR_W-1:0] addr_list [16];

    pullup (sda);

    ee_ctrl_top u_dut
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wdata    (wdata),
        .req_drop (req_drop),
        .done     (done),
        .done_tag (done_tag),
        .done_op  (done_op),
        .rd_data  (rd_data),
        .nack     (nack),
        .SCL      (scl),
        .SDA      (sda)
    );

    ee_eeprom_model u_eeprom
    (
        .scl (scl),
        .sda (sda)
    );

    ee_ctrl_checker u_checker
    (
        .CLK         (CLK),
        .RESET       (RESET),
        .wr          (wr),
        .rd          (rd),
        .addr        (addr),
        .wdata       (wdata),
        .req_drop    (req_drop),
        .done        (done),
        .done_tag    (done_tag),
        .done_op     (done_op),
        .rd_data     (rd_data),
        .nack        (nack),
        .scl         (scl),
        .sda         (sda),
        .error_count (error_count),
        .check_count (check_count),
        .done_count  (done_count),
        .drop_count  (drop_count),
        .busy_count  (busy_count),
        .idle_checks (idle_checks),
        .idle_errors (idle_errors)
    );

    initial
    begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // one strobe cycle, entered and left 1 ns after an edge
    task automatic send_req(input logic w, input logic r,
                            input logic [`EE_ADDR_W-1:0] ad, input logic [7:0] dt);
        begin
            wr    = w;
            rd    = r;
            addr  = ad;
            wdata = dt;
            @(posedge CLK);
            #1;
            wr = 1'b0;
            rd = 1'b0;
        end
    endtask

    task automatic rand_addr(output logic [`EE_ADDR_W-1:0] ad);
        begin
            ad = {3'({$random(seed)} % 7), 8'($random(seed))}; // blocks 0 to 6
        end
    endtask

    task automatic wait_drain;
        int limit;
        int n;
        begin
            limit = (`EE_FIFO_DEPTH + 2) * 39 * 4 * `EE_QUARTER_CYCLES * 2;
            n     = 0;
            while (busy_count != 0 && n < limit)
            begin
                @(posedge CLK);
                #1;
                n++;
            end
            if (busy_count != 0)
            begin
                fails++;
                $display("timeout: %0d completions still outstanding", busy_count);
            end
        end
    endtask

    task automatic end_test(input string name);
        int errs;
        begin
            errs = error_count + fails - mark;
            $display("%s: %s, %0d errors", name, (errs == 0) ? "ok" : "failed", errs);
            mark = error_count + fails;
        end
    endtask

    initial
    begin
        seed  = 32'hef6a_475d;
        RESET = 1'b1;
        wr    = 1'b0;
        rd    = 1'b0;
        addr  = '0;
        wdata = 8'h00;
        fails = 0;
        mark  = 0;
        repeat (8) @(posedge CLK);
        #1;
        RESET = 1'b0;
        repeat (2) @(posedge CLK);
        #1;

        for (i = 0; i < 16; i++)
        begin
            rand_addr(a);
            addr_list[i] = a;
            send_req(1'b1, 1'b0, a, 8'($random(seed)));
            wait_drain();
        end
        for (i = 0; i < 16; i++)
        begin
            send_req(1'b0, 1'b1, addr_list[i], 8'h00);
            wait_drain();
        end
        end_test("test 1 write then read back");

        for (i = 0; i < 40; i++)
        begin
            rand_addr(a);
            d = 8'($random(seed));
            if ($random(seed) & 1)
                send_req(1'b0, 1'b1, a, d);
            else
                send_req(1'b1, 1'b0, a, d);
            gap = {$random(seed)} % 401;
            repeat (gap)
            begin
                @(posedge CLK);
                #1;
            end
        end
        wait_drain();
        end_test("test 2 mixed random traffic");

        drops_before = drop_count;
        for (i = 0; i < 10; i++)
        begin
            rand_addr(a);
            d = 8'($random(seed));
            if ($random(seed) & 1)
                send_req(1'b0, 1'b1, a, d);
            else
                send_req(1'b1, 1'b0, a, d);
        end
        wait_drain();
        if (drop_count == drops_before)
        begin
            fails++;
            $display("queue overflow test: no request was dropped");
        end
        end_test("test 3 queue overflow");

        a = {3'd7, 8'($random(seed))};
        send_req(1'b1, 1'b0, a, 8'($random(seed)));
        wait_drain();
        send_req(1'b0, 1'b1, a, 8'h00);
        wait_drain();
        end_test("test 4 missing acknowledge");

        rand_addr(a);
        send_req(1'b1, 1'b1, a, 8'($random(seed))); // wr must win
        wait_drain();
        send_req(1'b0, 1'b1, a, 8'h00);
        wait_drain();
        end_test("test 5 simultaneous strobes");

        repeat (4) @(posedge CLK);
        $display("test 6 bus idle: %0d checks, %0d with the bus not idle",
                 idle_checks, idle_errors);
        $display("checks %0d, errors %0d, completions %0d, drops %0d",
                 check_count, error_count + fails, done_count, drop_count);
        if (error_count + fails == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired with %0d completions still outstanding", busy_count);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* list.f */
common/ee_cmd_pkg.sv
common/ee_bus_pkg.sv
+incdir+common
rtl/ee_req_capture.sv
rtl/ee_cmd_fifo.sv
ee_serial_engine/ee_bit_shifter.sv
ee_serial_engine/ee_serial_engine.sv
rtl/ee_ctrl_top.sv
verif/ee_eeprom_model.sv
verif/ee_ctrl_checker.sv
verif/ee_ctrl_tb.sv
